//--- Bender.yml
package:
  name: mem_access

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/store_align.sv
      - hdl/data_ram.sv
      - hdl/load_align.sv
      - hdl/mem_access_top.sv
  - target: simulation
    files:
      - bench/mem_access_tb.sv

//--- bench/mem_access_tb.sv
// Table-driven test of the data-memory path, one table entry per clock.
// Outputs for an entry are checked at the falling edge after the edge that samples it.
// RAM is undefined after reset, so every word is written before it is read.
// A store is readable by a load two entries later; the table keeps to that spacing.
// Random word data comes from $urandom with a fixed seed.
`timescale 1ns/100ps
`default_nettype none

module mem_access_tb;

    import lsu_pkg::*;

    typedef struct packed {
        logic        st;            // store strobe
        logic        ld;            // load strobe
        store_req_t  sreq;
        load_req_t   lreq;
        logic [31:0] exp_data;      // only meaningful with exp_valid
        logic        exp_valid;
        logic        exp_ld_mis;
        logic        exp_st_mis;
    } entry_t;

    localparam int RESET_CYCLES = 10;

    logic        clk;
    logic        reset_i;
    logic        st_en_i;
    store_req_t  st_req_i;
    logic        st_misalign_o;
    logic        ld_en_i;
    load_req_t   ld_req_i;
    logic        ld_valid_o;
    logic [31:0] ld_data_o;
    logic        ld_misalign_o;

    entry_t      table_q[$];
    logic [31:0] rnd [4];           // random words for the word test
    int          cycles;
    int          max_cycles;

    mem_access_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .st_en_i       (st_en_i),
        .st_req_i      (st_req_i),
        .st_misalign_o (st_misalign_o),
        .ld_en_i       (ld_en_i),
        .ld_req_i      (ld_req_i),
        .ld_valid_o    (ld_valid_o),
        .ld_data_o     (ld_data_o),
        .ld_misalign_o (ld_misalign_o)
    );

    always #2 clk = ~clk;           // 4 ns period

    // run limit, counted from time zero including reset
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the test table did not finish within %0d cycles", max_cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // flags are {valid, load misalign, store misalign}
    task automatic add_entry(input logic st, input logic [9:0] sa, input logic [1:0] ssz,
                             input logic [31:0] sd, input logic ld, input logic [9:0] la,
                             input logic [1:0] lsz, input logic lz,
                             input logic [31:0] exp_data, input logic [2:0] flags);
        entry_t e;
        e.st         = st;
        e.sreq.addr  = sa;
        e.sreq.size  = ssz;
        e.sreq.data  = sd;
        e.ld         = ld;
        e.lreq.addr  = la;
        e.lreq.size  = lsz;
        e.lreq.zext  = lz;
        e.exp_data   = exp_data;
        e.exp_valid  = flags[2];
        e.exp_ld_mis = flags[1];
        e.exp_st_mis = flags[0];
        table_q.push_back(e);
    endtask

    task automatic build_table();
        for (int k = 0; k < 4; k++) begin
            rnd[k] = $urandom;
        end
        // random words, each read back unsigned two entries after its store
        add_entry(1'b1, 10'h000, SZ_WORD, rnd[0], 1'b0, 10'h000, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h004, SZ_WORD, rnd[1], 1'b0, 10'h000, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h040, SZ_WORD, rnd[2], 1'b1, 10'h000, SZ_WORD, 1'b1, rnd[0], 3'b100);
        add_entry(1'b1, 10'h3fc, SZ_WORD, rnd[3], 1'b1, 10'h004, SZ_WORD, 1'b1, rnd[1], 3'b100);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h040, SZ_WORD, 1'b1, rnd[2], 3'b100);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h3fc, SZ_WORD, 1'b1, rnd[3], 3'b100);
        // byte lanes 1 and 3 over 0x11223344, upper data bits ignored
        add_entry(1'b1, 10'h100, SZ_WORD, 32'h11223344, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h101, SZ_BYTE, 32'h123456a5, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h103, SZ_BYTE, 32'h0000007e, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b0, 10'h000, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h100, SZ_WORD, 1'b1, 32'h7e22a544, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h101, SZ_BYTE, 1'b0, 32'hffffffa5, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h101, SZ_BYTE, 1'b1, 32'h000000a5, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h103, SZ_BYTE, 1'b0, 32'h0000007e, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h102, SZ_BYTE, 1'b1, 32'h00000022, 3'b100);
        // halves over 0xdeadbeef, 0x8000 and 0xf00d both negative
        add_entry(1'b1, 10'h200, SZ_WORD, 32'hdeadbeef, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h200, SZ_HALF, 32'habcd8000, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b1, 10'h202, SZ_HALF, 32'h0000f00d, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b0, 10'h000, SZ_BYTE, 1'b0, 32'h0, 3'b000);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h200, SZ_WORD, 1'b1, 32'hf00d8000, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h200, SZ_HALF, 1'b0, 32'hffff8000, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h200, SZ_HALF, 1'b1, 32'h00008000, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h202, SZ_HALF, 1'b0, 32'hfffff00d, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h202, SZ_HALF, 1'b1, 32'h0000f00d, 3'b100);
        // misaligned stores and loads, then the word must be unchanged
        add_entry(1'b1, 10'h201, SZ_HALF, 32'h55555555, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b001);
        add_entry(1'b1, 10'h202, SZ_WORD, 32'h66666666, 1'b0, 10'h0, SZ_BYTE, 1'b0, 32'h0, 3'b001);
        add_entry(1'b1, 10'h200, 2'd3, 32'h77777777, 1'b1, 10'h203, SZ_HALF, 1'b0, 32'h0, 3'b011);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h201, SZ_WORD, 1'b1, 32'h0, 3'b010);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h200, 2'd3, 1'b1, 32'h0, 3'b010);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h200, SZ_WORD, 1'b1, 32'hf00d8000, 3'b100);
        // back-to-back loads, then store and load together on different words
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h000, SZ_WORD, 1'b1, rnd[0], 3'b100);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h004, SZ_WORD, 1'b1, rnd[1], 3'b100);
        add_entry(1'b0, 10'h000, SZ_BYTE, 32'h0, 1'b1, 10'h040, SZ_WORD, 1'b1, rnd[2], 3'b100);
        add_entry(1'b1, 10'h300, SZ_WORD, 32'hcafef00d, 1'b1, 10'h3fc, SZ_WORD, 1'b1, rnd[3], 3'b100);
        add_entry(1'b1, 10'h304, SZ_WORD, 32'h0badbeef, 1'b1, 10'h100, SZ_WORD, 1'b1,
                  32'h7e22a544, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h300, SZ_WORD, 1'b1, 32'hcafef00d, 3'b100);
        add_entry(1'b0, 10'h0, SZ_BYTE, 32'h0, 1'b1, 10'h304, SZ_WORD, 1'b1, 32'h0badbeef, 3'b100);
    endtask

    task automatic drive_entry(input entry_t e);
        st_en_i  <= e.st;
        st_req_i <= e.sreq;
        ld_en_i  <= e.ld;
        ld_req_i <= e.lreq;
    endtask

    task automatic check_entry(input int i);
        entry_t e;
        e = table_q[i];
        check_value(st_misalign_o, e.exp_st_mis, $sformatf("entry %0d store misalign", i));
        check_value(ld_misalign_o, e.exp_ld_mis, $sformatf("entry %0d load misalign", i));
        if (e.exp_valid && ld_valid_o !== 1'b1) begin
            $display("Load of table entry %0d gave no valid pulse one cycle after its strobe", i);
            $display("STATUS: FAIL");
            $fatal(1);
        end
        check_value(ld_valid_o, e.exp_valid, $sformatf("entry %0d load valid", i));  // spurious
        if (e.exp_valid) begin
            check_value(ld_data_o, e.exp_data, $sformatf("entry %0d load data", i));
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        st_en_i    = 1'b0;
        st_req_i   = '0;
        ld_en_i    = 1'b0;
        ld_req_i   = '0;
        cycles     = 0;
        void'($urandom(83607));
        build_table();
        max_cycles = table_q.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i <= table_q.size(); i++) begin
            @(posedge clk);
            if (i < table_q.size()) begin
                drive_entry(table_q[i]);
            end else begin
                drive_entry('0);            // idle after the last entry
            end
            if (i > 0) begin
                @(negedge clk);             // previous entry sampled at this rising edge
                check_entry(i - 1);
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
// Word-organized data RAM, DEPTH words of DATA_W bits.
// Write is synchronous with a per-byte mask; read is asynchronous,
// so the read port maps to distributed RAM or a write-first model on block RAM.
// Contents are undefined after power-up; there is no init file.
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  lsu_pkg::ram_wr_t            wr_i,
    input  logic [lsu_pkg::WORD_AW-1:0] raddr_i,   // word address
    output logic [lsu_pkg::DATA_W-1:0]  rdata_o
);

    import lsu_pkg::*;

    (* ram_style = "block" *) logic [DATA_W-1:0] mem [0:DEPTH-1];

    // byte-lane write, lanes without a mask bit keep their old value
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (wr_i.mask[b]) begin
                    mem[wr_i.word_addr][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                end
            end
        end
    end

    // combinational read, a same-cycle write shows up after the edge
    assign rdata_o = mem[raddr_i];

    // an X address would smear the write across the array in simulation
    a_waddr_known: assert property (@(posedge clk)
        wr_en_i |-> !$isunknown(wr_i.word_addr));

    // mask must be known too, else lanes are written at random
    a_wmask_known: assert property (@(posedge clk)
        wr_en_i |-> !$isunknown(wr_i.mask));

endmodule

`default_nettype wire

//--- hdl/load_align.sv
// Load side of the data path: reads the addressed word from the RAM,
// picks the byte or half lane, extends it and registers the result.
// A load strobed at edge N gives ld_valid_o (or ld_misalign_o) after N,
// for exactly one cycle. ld_data_o holds its last value between loads.
// One load per cycle is accepted; there is no stall.
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        ld_en_i,    // one-cycle load strobe
    input  lsu_pkg::load_req_t          ld_req_i,
    output logic [lsu_pkg::WORD_AW-1:0] raddr_o,    // to RAM, word address
    input  logic [lsu_pkg::DATA_W-1:0]  rdata_i,    // from RAM, same cycle
    output logic                        ld_valid_o,
    output logic [lsu_pkg::DATA_W-1:0]  ld_data_o,
    output logic                        ld_misalign_o
);

    import lsu_pkg::*;

    rd_word_u          rd_w;       // read word, lane views
    logic [7:0]        byte_lane;
    logic [15:0]       half_lane;
    logic              sext;       // sign bit is propagated
    logic              aligned;
    logic [DATA_W-1:0] ext_data;   // extended result before the register

    assign raddr_o = ld_req_i.addr[ADDR_W-1:2];
    assign rd_w    = rdata_i;
    assign aligned = is_aligned(ld_req_i.size, ld_req_i.addr[1:0]);
    assign sext    = ~ld_req_i.zext;

    assign byte_lane = rd_w.bytes[ld_req_i.addr[1:0]];
    assign half_lane = rd_w.halves[ld_req_i.addr[1]];  // addr[0] is 0 when aligned

    always_comb begin
        case (ld_req_i.size)
            SZ_BYTE: ext_data = {{(DATA_W-8){byte_lane[7] & sext}}, byte_lane};
            SZ_HALF: ext_data = {{(DATA_W-16){half_lane[15] & sext}}, half_lane};
            default: ext_data = rd_w;   // word; size 3 never validates
        endcase
    end

    // strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ld_valid_o    <= 1'b0;
            ld_misalign_o <= 1'b0;
        end else begin
            ld_valid_o    <= ld_en_i & aligned;
            ld_misalign_o <= ld_en_i & ~aligned;   // instead of valid
        end
    end

    // result data, only updated by a good load
    always_ff @(posedge clk) begin
        if (ld_en_i && aligned) begin
            ld_data_o <= ext_data;
        end
    end

    // a load reports good data or a misalign, never both
    a_ld_excl: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({ld_valid_o, ld_misalign_o}));

endmodule

`default_nettype wire

//--- hdl/lsu_pkg.sv
// Shared widths, access size codes and request types for the data-memory path.
// 1 KiB of data memory, word organized, little-endian byte lanes.
// The size code 3 is not a legal access and is always treated as misaligned.
`default_nettype none

package lsu_pkg;

    localparam int ADDR_W  = 10;            // byte address, 1 KiB
    localparam int DATA_W  = 32;
    localparam int NBYTES  = DATA_W / 8;    // byte lanes per word
    localparam int WORD_AW = ADDR_W - 2;    // drop the byte offset
    localparam int DEPTH   = 1 << WORD_AW;  // 256 words

    // access size codes
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    // store request from the core, data right-justified
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        size;
        logic [DATA_W-1:0] data;
    } store_req_t;

    // load request, zext set for the unsigned forms (lbu/lhu)
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        size;
        logic              zext;
    } load_req_t;

    // word write into the RAM, data already sitting in its lanes
    typedef struct packed {
        logic [WORD_AW-1:0] word_addr;
        logic [NBYTES-1:0]  mask;       // one bit per byte lane
        logic [DATA_W-1:0]  data;
    } ram_wr_t;

    // read word, seen as byte lanes or as half lanes
    typedef union packed {
        logic [NBYTES-1:0][7:0]    bytes;   // bytes[0] at offset 0
        logic [NBYTES/2-1:0][15:0] halves;  // halves[0] at offset 0
    } rd_word_u;

    // natural alignment check, shared by the store and load sides
    function automatic logic is_aligned(input logic [1:0] size, input logic [1:0] lo);
        logic ok;
        case (size)
            SZ_BYTE: ok = 1'b1;             // any offset
            SZ_HALF: ok = ~lo[0];           // offset 0 or 2
            SZ_WORD: ok = (lo == 2'b00);
            default: ok = 1'b0;             // code 3 is never legal
        endcase
        return ok;
    endfunction

endpackage

`default_nettype wire

//--- hdl/mem_access_top.sv
// Data-memory path of the core: store formatting, masked RAM, load alignment.
// One store and one load may be strobed in the same cycle, every cycle.
// A store becomes visible to loads strobed two edges after its own strobe;
// there is no forwarding, so an earlier load to that word sees the old data.
// Misaligned accesses are flagged and dropped; there are no other exceptions.
`timescale 1ns/100ps
`default_nettype none

module mem_access_top (
    input  logic                       clk,
    input  logic                       reset_i,
    // store port
    input  logic                       st_en_i,
    input  lsu_pkg::store_req_t        st_req_i,
    output logic                       st_misalign_o,
    // load port
    input  logic                       ld_en_i,
    input  lsu_pkg::load_req_t         ld_req_i,
    output logic                       ld_valid_o,
    output logic [lsu_pkg::DATA_W-1:0] ld_data_o,
    output logic                       ld_misalign_o
);

    import lsu_pkg::*;

    logic               wr_en;      // registered write strobe
    ram_wr_t            wr;         // word address, lane mask, lane data
    logic [WORD_AW-1:0] raddr;
    logic [DATA_W-1:0]  rdata;      // async read word

    store_align u_store_align (
        .clk           (clk),
        .reset_i       (reset_i),
        .st_en_i       (st_en_i),
        .st_req_i      (st_req_i),
        .wr_en_o       (wr_en),
        .wr_o          (wr),
        .st_misalign_o (st_misalign_o)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .wr_en_i (wr_en),
        .wr_i    (wr),
        .raddr_i (raddr),
        .rdata_o (rdata)
    );

    load_align u_load_align (
        .clk           (clk),
        .reset_i       (reset_i),
        .ld_en_i       (ld_en_i),
        .ld_req_i      (ld_req_i),
        .raddr_o       (raddr),
        .rdata_i       (rdata),
        .ld_valid_o    (ld_valid_o),
        .ld_data_o     (ld_data_o),
        .ld_misalign_o (ld_misalign_o)
    );

endmodule

`default_nettype wire

//--- hdl/store_align.sv
// Turns a byte-addressed store into one registered, byte-masked word write.
// A store strobed at edge N is presented to the RAM after N and lands at N+1.
// Misaligned stores raise st_misalign_o for one cycle and write nothing.
// wr_o is only meaningful while wr_en_o is high.
`timescale 1ns/100ps
`default_nettype none

module store_align (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                st_en_i,        // one-cycle store strobe
    input  lsu_pkg::store_req_t st_req_i,
    output logic                wr_en_o,
    output lsu_pkg::ram_wr_t    wr_o,
    output logic                st_misalign_o
);

    import lsu_pkg::*;

    logic    aligned;
    ram_wr_t wr_c;      // formatted write, before the register

    assign aligned = is_aligned(st_req_i.size, st_req_i.addr[1:0]);

    // mask from size and offset, data replicated so every lane carries it
    always_comb begin
        wr_c.word_addr = st_req_i.addr[ADDR_W-1:2];
        case (st_req_i.size)
            SZ_BYTE: begin
                wr_c.mask = 4'b0001 << st_req_i.addr[1:0];
                wr_c.data = {NBYTES{st_req_i.data[7:0]}};         // byte 0 into all lanes
            end
            SZ_HALF: begin
                wr_c.mask = st_req_i.addr[1] ? 4'b1100 : 4'b0011;
                wr_c.data = {(NBYTES/2){st_req_i.data[15:0]}};    // half 0 into both
            end
            SZ_WORD: begin
                wr_c.mask = 4'b1111;
                wr_c.data = st_req_i.data;
            end
            default: begin
                wr_c.mask = 4'b0000;        // illegal size, flagged below
                wr_c.data = st_req_i.data;
            end
        endcase
    end

    // control register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_en_o       <= 1'b0;
            st_misalign_o <= 1'b0;
        end else begin
            wr_en_o       <= st_en_i & aligned;
            st_misalign_o <= st_en_i & ~aligned;   // level for one cycle
        end
    end

    // payload register, loaded only on a strobe
    always_ff @(posedge clk) begin
        if (st_en_i) begin
            wr_o <= wr_c;
        end
    end

    // an enabled write always touches at least one lane
    a_wr_mask_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_o |-> (wr_o.mask != '0));

endmodule

`default_nettype wire

//--- sources.f
hdl/lsu_pkg.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/mem_access_top.sv
bench/mem_access_tb.sv
